//--- rtl/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int          ram_words = 256,
    parameter logic [31:0] reset_pc  = 32'h0
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        enable,   // Level enable, low freezes every register
    input  logic [31:0] rom_data,
    output logic [31:0] rom_address,
    output logic [5:0]  led
);
    // Fetch to decode
    logic [31:0]        if_pc;
    cpu_pkg::instr_t    if_instr;
    logic               stall;

    // Register file read port
    cpu_pkg::reg_addr_t rs1_addr;
    cpu_pkg::reg_addr_t rs2_addr;
    logic [31:0]        rs1_value;
    logic [31:0]        rs2_value;

    // Pipeline registers
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::mem_wb_t   mem_wb;

    // Branch redirect from execute
    logic               flush;
    logic [31:0]        branch_target;

    fetch #(.reset_pc(reset_pc)) u_fetch (
        .clock         (clock),
        .rst           (rst),
        .enable        (enable),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .rom_data      (rom_data),
        .rom_address   (rom_address),
        .if_pc         (if_pc),
        .if_instr      (if_instr)
    );

    decode u_decode (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .flush     (flush),
        .if_pc     (if_pc),
        .if_instr  (if_instr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .stall     (stall),
        .id_ex     (id_ex)
    );

    register_bank u_register_bank (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .mem_wb    (mem_wb)
    );

    execute u_execute (
        .clock         (clock),
        .rst           (rst),
        .enable        (enable),
        .id_ex         (id_ex),
        .mem_wb        (mem_wb),
        .ex_mem        (ex_mem),
        .flush         (flush),
        .branch_target (branch_target)
    );

    memory #(.ram_words(ram_words)) u_memory (
        .clock  (clock),
        .rst    (rst),
        .enable (enable),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .led    (led)
    );

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [4:0] reg_addr_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b   // lui result is the immediate
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] imm;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        alu_op_e     alu_op;
        logic        alu_src;     // Operand b from imm
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        logic        branch;
        logic        branch_ne;   // bne rather than beq
    } id_ex_t;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] store_data;
        reg_addr_t   rd;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] load_data;
        reg_addr_t   rd;
        logic        mem_to_reg;
        logic        reg_write;
    } mem_wb_t;

endpackage

//--- rtl/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic               clock,
    input  logic               rst,
    input  logic               enable,
    input  logic               flush,
    input  logic [31:0]        if_pc,
    input  cpu_pkg::instr_t    if_instr,
    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  logic [31:0]        rs1_value,
    input  logic [31:0]        rs2_value,
    output logic               stall,
    output cpu_pkg::id_ex_t    id_ex
);
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    cpu_pkg::id_ex_t    decoded;
    cpu_pkg::alu_op_e   funct3_op;
    logic               funct3_ok;
    logic               valid;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               stall_prev;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [31:0]        imm_i;
    logic [31:0]        imm_s;
    logic [31:0]        imm_b;
    logic [31:0]        imm_u;

    assign opcode   = if_instr.r_fmt.opcode;
    assign funct3   = if_instr.r_fmt.funct3;
    assign rs1_addr = if_instr.r_fmt.rs1;
    assign rs2_addr = if_instr.r_fmt.rs2;

    assign imm_i = {{20{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.imm};
    assign imm_s = {{20{if_instr.s_fmt.imm_hi[6]}}, if_instr.s_fmt.imm_hi, if_instr.s_fmt.imm_lo};
    assign imm_b = {{19{if_instr.b_fmt.imm12}}, if_instr.b_fmt.imm12, if_instr.b_fmt.imm11,
                    if_instr.b_fmt.imm10_5, if_instr.b_fmt.imm4_1, 1'b0};
    assign imm_u = {if_instr.i_fmt.imm, if_instr.i_fmt.rs1, if_instr.i_fmt.funct3, 12'b0};

    // Shared by register and immediate arithmetic
    always_comb begin
        funct3_ok = 1'b1;
        case (funct3)
            3'b000:  funct3_op = cpu_pkg::alu_add;
            3'b010:  funct3_op = cpu_pkg::alu_slt;
            3'b100:  funct3_op = cpu_pkg::alu_xor;
            3'b110:  funct3_op = cpu_pkg::alu_or;
            3'b111:  funct3_op = cpu_pkg::alu_and;
            default: begin
                funct3_op = cpu_pkg::alu_add;
                funct3_ok = 1'b0;   // Shifts and sltu not supported
            end
        endcase
    end

    always_comb begin
        decoded           = '0;
        decoded.pc        = if_pc;
        decoded.rs1_value = rs1_value;
        decoded.rs2_value = rs2_value;
        decoded.rs1       = rs1_addr;
        decoded.rs2       = rs2_addr;
        decoded.rd        = if_instr.r_fmt.rd;
        decoded.alu_op    = cpu_pkg::alu_add;
        valid    = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opcode)
            op_reg: begin
                uses_rs2          = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = (funct3 == 3'b000 && if_instr.r_fmt.funct7[5]) ?
                                    cpu_pkg::alu_sub : funct3_op;
                valid             = funct3_ok;
            end
            op_imm: begin
                decoded.imm       = imm_i;
                decoded.alu_src   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = funct3_op;
                valid             = funct3_ok;
            end
            op_lui: begin
                uses_rs1          = 1'b0;
                decoded.imm       = imm_u;
                decoded.alu_src   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = cpu_pkg::alu_pass_b;
            end
            op_load: begin
                decoded.imm       = imm_i;
                decoded.alu_src   = 1'b1;
                decoded.mem_read  = 1'b1;
                decoded.reg_write = 1'b1;
            end
            op_store: begin
                uses_rs2          = 1'b1;
                decoded.imm       = imm_s;
                decoded.alu_src   = 1'b1;
                decoded.mem_write = 1'b1;
            end
            op_branch: begin
                uses_rs2          = 1'b1;
                decoded.imm       = imm_b;
                decoded.branch    = 1'b1;
                decoded.branch_ne = funct3[0];
                valid             = (funct3[2:1] == 2'b00);   // beq and bne only
            end
            default: begin
                valid    = 1'b0;
                uses_rs1 = 1'b0;
            end
        endcase
    end

    // Load result arrives one cycle too late for the instruction behind it
    assign stall = id_ex.mem_read &&
                   ((uses_rs1 && id_ex.rd == rs1_addr) || (uses_rs2 && id_ex.rd == rs2_addr));

    always_ff @(posedge clock) begin
        if (rst) begin
            id_ex      <= '0;
            stall_prev <= 1'b0;
        end else if (enable) begin
            id_ex      <= decoded;
            stall_prev <= stall;
            if (flush || stall || !valid) begin   // Bubble
                id_ex.reg_write <= 1'b0;
                id_ex.mem_read  <= 1'b0;
                id_ex.mem_write <= 1'b0;
                id_ex.branch    <= 1'b0;
            end
        end
    end

    // The bubble behind a stall can never be a load again
    single_cycle_stall: assert property (@(posedge clock) disable iff (rst)
        enable && stall_prev |-> !stall)
        else $error("FAIL %0t single_cycle_stall: stall %b stall_prev %b",
                    $time, stall, stall_prev);

endmodule

//--- rtl/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic             clock,
    input  logic             rst,
    input  logic             enable,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::mem_wb_t mem_wb,
    output cpu_pkg::ex_mem_t ex_mem,
    output logic             flush,
    output logic [31:0]      branch_target
);
    logic        ex_hit_a;
    logic        ex_hit_b;
    logic        wb_hit_a;
    logic        wb_hit_b;
    logic [31:0] wb_value;
    logic [31:0] op_a;
    logic [31:0] rs2_fwd;
    logic [31:0] op_b;
    logic [31:0] result;
    logic        equal;

    // EX/MEM holds the younger result so it wins over MEM/WB
    assign ex_hit_a = ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == id_ex.rs1;
    assign ex_hit_b = ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == id_ex.rs2;
    assign wb_hit_a = mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == id_ex.rs1;
    assign wb_hit_b = mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == id_ex.rs2;

    assign wb_value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    always_comb begin
        if (ex_hit_a)
            op_a = ex_mem.result;
        else if (wb_hit_a)
            op_a = wb_value;
        else
            op_a = id_ex.rs1_value;
        if (ex_hit_b)
            rs2_fwd = ex_mem.result;
        else if (wb_hit_b)
            rs2_fwd = wb_value;
        else
            rs2_fwd = id_ex.rs2_value;
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : rs2_fwd;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::alu_add:    result = op_a + op_b;
            cpu_pkg::alu_sub:    result = op_a - op_b;
            cpu_pkg::alu_and:    result = op_a & op_b;
            cpu_pkg::alu_or:     result = op_a | op_b;
            cpu_pkg::alu_xor:    result = op_a ^ op_b;
            cpu_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_pass_b: result = op_b;
            default:             result = '0;
        endcase
    end

    // Branch compares the forwarded registers, not the ALU output
    assign equal         = (op_a == rs2_fwd);
    assign flush         = id_ex.branch && (equal ^ id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (enable) begin
            ex_mem.result     <= result;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
    end

    // Decode must turn the slot behind a taken branch into a bubble
    flush_bubble: assert property (@(posedge clock) disable iff (rst)
        enable && flush |=> !(id_ex.mem_read || id_ex.mem_write || id_ex.reg_write))
        else $error("FAIL %0t flush_bubble: mem_read %b mem_write %b reg_write %b expected 0",
                    $time, id_ex.mem_read, id_ex.mem_write, id_ex.reg_write);

endmodule

//--- rtl/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  logic            stall,
    input  logic            flush,
    input  logic [31:0]     branch_target,
    input  cpu_pkg::instr_t rom_data,
    output logic [31:0]     rom_address,
    output logic [31:0]     if_pc,
    output cpu_pkg::instr_t if_instr
);
    logic [31:0] pc;

    assign rom_address = pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= reset_pc;
            if_pc    <= '0;
            if_instr <= '0;
        end else if (enable) begin
            if (flush) begin
                pc       <= branch_target;
                if_instr <= '0;   // All-zero word decodes as a bubble
            end else if (!stall) begin
                pc       <= pc + 32'd4;
                if_pc    <= pc;
                if_instr <= rom_data;
            end
        end
    end

    // Redirects and reset_pc must both keep the fetch address on a word
    pc_word_aligned: assert property (@(posedge clock) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("FAIL %0t pc_word_aligned: pc %h expected low bits 00", $time, pc);

endmodule

//--- rtl/memory.sv
`timescale 1ns/1ps

module memory #(
    parameter int ram_words = 256
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             enable,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::mem_wb_t mem_wb,
    output logic [5:0]       led
);
    localparam int addr_bits = $clog2(ram_words);

    logic [31:0]          ram [ram_words];
    logic [addr_bits-1:0] word_index;
    logic [31:0]          load_data;

    assign word_index = ex_mem.result[addr_bits+1:2];   // Byte offset ignored
    assign load_data  = ram[word_index];

    always_ff @(posedge clock) begin
        if (enable && ex_mem.mem_write)
            ram[word_index] <= ex_mem.store_data;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_wb <= '0;
            led    <= '0;
        end else if (enable) begin
            mem_wb.alu_result <= ex_mem.result;
            mem_wb.load_data  <= load_data;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.mem_to_reg <= ex_mem.mem_read;
            mem_wb.reg_write  <= ex_mem.reg_write;
            if (ex_mem.reg_write)
                led <= ex_mem.result[5:0];   // Last register result, loads show address
        end
    end

    // Upper address bits are dropped by the index, so catch aliasing here
    ram_in_range: assert property (@(posedge clock) disable iff (rst)
        (ex_mem.mem_read || ex_mem.mem_write) |-> ex_mem.result[31:2] < ram_words)
        else $error("FAIL %0t ram_in_range: word %0d expected below %0d",
                    $time, ex_mem.result[31:2], ram_words);

endmodule

//--- rtl/register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic               clock,
    input  logic               rst,
    input  logic               enable,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output logic [31:0]        rs1_value,
    output logic [31:0]        rs2_value,
    input  cpu_pkg::mem_wb_t   mem_wb
);
    logic [31:0] regs [32];
    logic [31:0] wb_value;

    assign wb_value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    always_ff @(posedge clock) begin
        if (enable && !rst && mem_wb.reg_write)
            regs[mem_wb.rd] <= wb_value;   // x0 is masked on read
    end

    // Write-through so decode sees a value written on the same edge
    always_comb begin
        if (rs1_addr == '0)
            rs1_value = '0;
        else if (mem_wb.reg_write && mem_wb.rd == rs1_addr)
            rs1_value = wb_value;
        else
            rs1_value = regs[rs1_addr];
        if (rs2_addr == '0)
            rs2_value = '0;
        else if (mem_wb.reg_write && mem_wb.rd == rs2_addr)
            rs2_value = wb_value;
        else
            rs2_value = regs[rs2_addr];
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    echo "Testbench reported a failure, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- sim.f
+incdir+sim
rtl/cpu_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/register_bank.sv
rtl/execute.sv
rtl/memory.sv
rtl/cpu.sv
sim/tb_cpu.sv

//--- sim/tb_program.svh
`ifndef tb_program_svh
`define tb_program_svh

localparam logic [6:0] op_imm  = 7'b0010011;
localparam logic [6:0] op_load = 7'b0000011;

// Program plus load-use stall, two flushes and three turns of the final loop
localparam int run_edges = 33;

function automatic logic [31:0] r_type(input int funct7, input int rs2, input int rs1,
                                       input int funct3, input int rd);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opcode, input int imm, input int rs1,
                                       input int funct3, input int rd);
    return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode};
endfunction

function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// Offset in bytes, bit 0 dropped
function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                       input int funct3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
            7'b1100011};
endfunction

function automatic logic [31:0] u_type(input int imm, input int rd);
    return {imm[19:0], rd[4:0], 7'b0110111};
endfunction

task automatic load_program();
    foreach (rom[i])
        rom[i] = '0;   // Zero word has no valid opcode
    rom[0]  = i_type(op_imm, 5, 0, 0, 1);      // addi x1, x0, 5
    rom[1]  = i_type(op_imm, 3, 1, 0, 2);      // addi x2, x1, 3
    rom[2]  = r_type(0, 2, 1, 0, 3);           // add x3, x1, x2
    rom[3]  = r_type(32, 1, 3, 0, 4);          // sub x4, x3, x1
    rom[4]  = i_type(op_imm, 15, 4, 4, 5);     // xori x5, x4, 15
    rom[5]  = r_type(0, 3, 5, 6, 6);           // or x6, x5, x3
    rom[6]  = i_type(op_imm, 12, 6, 7, 7);     // andi x7, x6, 12
    rom[7]  = r_type(0, 6, 7, 2, 8);           // slt x8, x7, x6
    rom[8]  = u_type(32'h12345, 10);           // lui x10, 0x12345
    rom[9]  = i_type(op_imm, 42, 10, 6, 11);   // ori x11, x10, 42
    rom[10] = i_type(op_imm, 9, 4, 2, 9);      // slti x9, x4, 9
    rom[11] = i_type(op_imm, 64, 0, 0, 12);    // addi x12, x0, 64
    rom[12] = s_type(4, 11, 12);               // sw x11, 4(x12)
    rom[13] = i_type(op_load, 4, 12, 2, 13);   // lw x13, 4(x12)
    rom[14] = r_type(0, 9, 13, 0, 14);         // add x14, x13, x9 after load-use stall
    rom[15] = b_type(12, 13, 14, 1);           // bne x14, x13, taken
    rom[16] = i_type(op_imm, 60, 0, 0, 15);    // Flushed
    rom[17] = i_type(op_imm, 61, 0, 0, 15);    // Flushed
    rom[18] = i_type(op_imm, 2, 14, 0, 16);    // addi x16, x14, 2
    rom[19] = b_type(8, 14, 16, 0);            // beq x16, x14, not taken
    rom[20] = i_type(op_imm, 9, 0, 0, 17);     // addi x17, x0, 9
    rom[21] = b_type(12, 17, 17, 0);           // beq x17, x17, taken
    rom[22] = i_type(op_imm, 62, 0, 0, 18);    // Flushed
    rom[23] = i_type(op_imm, 63, 0, 0, 18);    // Flushed
    rom[24] = r_type(32, 16, 17, 0, 19);       // sub x19, x17, x16
    rom[25] = r_type(0, 17, 19, 7, 20);        // and x20, x19, x17
    rom[26] = b_type(0, 0, 0, 0);              // beq x0, x0, 0 spins here
    // Low 6 bits of each register write, the lw shows its address
    expected_led = '{5, 8, 13, 8, 7, 15, 12, 1, 0, 42, 1, 0, 4, 43, 45, 9, 28, 8};
    // Word index on rom_address after each enabled edge
    expected_fetch = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15,
                       15, 16, 17, 18, 19, 20, 21, 22, 23, 24, 25, 26, 27, 28,
                       26, 27, 28, 26};
endtask

`endif

//--- sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    localparam int clock_period = 40;
    localparam int reset_cycles = 2;

    logic        clock;
    logic        rst;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    logic [5:0]  led;

    logic [31:0] rom [64];
    int          expected_led[$];
    int          expected_fetch[$];
    logic [31:0] lfsr = 32'h16b;
    int          addr_errors = 0;
    int          led_errors = 0;
    int          other_errors = 0;
    int          enabled_edges = 0;
    int          led_index = 0;
    logic        rst_used = 1'b1;      // Values seen by the last rising edge
    logic        enable_used = 1'b0;
    logic [31:0] last_address = '0;
    logic [5:0]  last_led = '0;

    `include "tb_program.svh"

    cpu #(.ram_words(256), .reset_pc(32'h0)) u_dut (
        .clock       (clock),
        .rst         (rst),
        .enable      (enable),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .led         (led)
    );

    assign rom_data = rom[rom_address[7:2]];

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        repeat (count) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // Enable drops for one to four cycles at about one edge in eight
    task automatic pause_at_random();
        int gap;
        int hold;
        forever begin
            @(posedge clock);
            draw_bits(3, gap);
            if (gap == 0) begin
                draw_bits(2, hold);
                enable <= 1'b0;
                repeat (hold + 1) @(posedge clock);
                enable <= 1'b1;
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(negedge clock) begin
        logic [31:0] expected_address;
        if (rst_used) begin
            assert (rom_address == 32'h0) else begin
                addr_errors++;
                $display("FAIL %0t rom_address: got %h expected %h", $time, rom_address, 32'h0);
            end
            assert (led == 6'd0) else begin
                led_errors++;
                $display("FAIL %0t led: got %0d expected 0", $time, led);
            end
        end else if (enable_used) begin
            enabled_edges++;
            if (enabled_edges <= expected_fetch.size()) begin
                expected_address = 32'(expected_fetch[enabled_edges - 1] * 4);
                assert (rom_address == expected_address) else begin
                    addr_errors++;
                    $display("FAIL %0t rom_address: got %h expected %h",
                             $time, rom_address, expected_address);
                end
            end
        end else begin
            assert (rom_address == last_address) else begin   // Frozen
                addr_errors++;
                $display("FAIL %0t rom_address: got %h expected %h",
                         $time, rom_address, last_address);
            end
            assert (led == last_led) else begin
                led_errors++;
                $display("FAIL %0t led: got %0d expected %0d", $time, led, last_led);
            end
        end
        if (!rst_used && led != last_led) begin
            if (led_index < expected_led.size()) begin
                assert (int'(led) == expected_led[led_index]) else begin
                    led_errors++;
                    $display("FAIL %0t led: got %0d expected %0d",
                             $time, led, expected_led[led_index]);
                end
            end else begin
                other_errors++;
                $display("led changed to %0d after the last expected value", led);
            end
            led_index++;
        end
        last_address = rom_address;
        last_led     = led;
        rst_used     = rst;
        enable_used  = enable;
    end

    initial begin
        rst    = 1'b1;
        enable = 1'b0;
        load_program();
        repeat (reset_cycles) @(posedge clock);
        rst    <= 1'b0;
        enable <= 1'b1;
        fork
            pause_at_random();
        join_none
        wait (enabled_edges == expected_fetch.size());
        assert (led_index == expected_led.size()) else begin
            other_errors++;
            $display("Only %0d of %0d expected led values appeared",
                     led_index, expected_led.size());
        end
        $display("Errors: rom_address %0d, led %0d, other %0d",
                 addr_errors, led_errors, other_errors);
        if (addr_errors + led_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Twice the undisturbed run leaves room for the enable pauses
    initial begin
        #((run_edges + reset_cycles) * 2 * clock_period);
        $display("Timeout: the processor did not reach %0d enabled edges", run_edges);
        $display("Errors: rom_address %0d, led %0d, other %0d",
                 addr_errors, led_errors, other_errors);
        $display("Something failed");
        $finish;
    end

endmodule
